//--- Makefile
.PHONY: sim clean

# build and run, the pass line in the output decides the status
sim:
	verilator --binary --timing --assert --top-module keyboard_tb -f list.f -o keyboard_sim
	@out="$$(./obj_dir/keyboard_sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST PASS$$"

clean:
	rm -rf obj_dir

//--- list.f
+incdir+logic
logic/kbd_pkg.sv
logic/ps2_rx.sv
logic/scan_decoder.sv
logic/key_tracker.sv
logic/keyboard_top.sv
sim/keyboard_assertions.sv
sim/keyboard_tb.sv

//--- logic/kbd_cfg.svh
// keyboard front end constants, include wherever scan codes, key positions or the timeout are used
`ifndef KBD_CFG_SVH
`define KBD_CFG_SVH

// number of tracked keys, one bit each in the key vector
`define KBD_NUM_KEYS 15

// key vector bit positions, digits first
`define KBD_KEY_0        0
`define KBD_KEY_1        1
`define KBD_KEY_2        2
`define KBD_KEY_3        3
`define KBD_KEY_4        4
`define KBD_KEY_5        5
`define KBD_KEY_6        6
`define KBD_KEY_7        7
`define KBD_KEY_8        8
`define KBD_KEY_9        9
`define KBD_KEY_MINUS    10
`define KBD_KEY_LBRACKET 11
`define KBD_KEY_RBRACKET 12
`define KBD_KEY_SPACE    13
`define KBD_KEY_ENTER    14

// scan code set 2 make codes, all primary
`define KBD_CODE_0        8'h45
`define KBD_CODE_1        8'h16
`define KBD_CODE_2        8'h1E
`define KBD_CODE_3        8'h26
`define KBD_CODE_4        8'h25
`define KBD_CODE_5        8'h2E
`define KBD_CODE_6        8'h36
`define KBD_CODE_7        8'h3D
`define KBD_CODE_8        8'h3E
`define KBD_CODE_9        8'h46
`define KBD_CODE_MINUS    8'h4E
`define KBD_CODE_LBRACKET 8'h54
`define KBD_CODE_RBRACKET 8'h5B
`define KBD_CODE_SPACE    8'h29
`define KBD_CODE_ENTER    8'h5A

// prefix bytes
`define KBD_PREFIX_EXT   8'hE0
`define KBD_PREFIX_BREAK 8'hF0

// system clocks of idle-high ps/2 clock before a partial frame is dropped
`define KBD_RX_TIMEOUT 4096

`endif

//--- logic/kbd_pkg.sv
// shared types of the keyboard front end, imported by every stage and the testbench
`default_nettype none

`include "kbd_cfg.svh"

package kbd_pkg;

    // one byte as it comes off the ps/2 line
    typedef logic [7:0] scan_byte_t;

    // index of a single tracked key
    // 4 bits covers the fifteen keys with one code spare
    typedef logic [3:0] key_index_t;

    // pressed state, one bit per tracked key
    typedef logic [`KBD_NUM_KEYS-1:0] key_vector_t;

    // what the decoder expects next
    // st_make      plain code presses a key
    // st_break     after f0, plain code releases a key
    // st_ext_make  after e0, byte is ignored
    // st_ext_break after e0 f0, byte is ignored
    typedef enum logic [1:0] {
        st_make      = 2'b00,
        st_break     = 2'b01,
        st_ext_make  = 2'b10,
        st_ext_break = 2'b11
    } decode_state_e;

endpackage

`default_nettype wire

//--- logic/key_tracker.sv
// key state stage, keeps one pressed bit per key and drives the hold or pulse key vector
`default_nettype none

`include "kbd_cfg.svh"

module key_tracker
    import kbd_pkg::*;
(
    input  wire          clock,
    input  wire          reset,
    input  wire          pulse_mode,
    input  wire          key_valid,
    input  key_index_t   key_index,
    input  wire          key_make,
    output key_vector_t  keys
);

    // live keyboard state
    key_vector_t press_vec;
    // press state one cycle late
    key_vector_t lock_vec;
    // lock bits that suppress the output
    key_vector_t lock_mask;

    // event writes its key only, spare index ignored
    always_ff @(posedge clock) begin
        if (!reset) begin
            press_vec <= '0;
        end else if (key_valid && (key_index < `KBD_NUM_KEYS)) begin
            press_vec[key_index] <= key_make;
        end
    end

    // lock rises a cycle after press and falls a cycle after release
    always_ff @(posedge clock) begin
        if (!reset) begin
            lock_vec <= '0;
        end else begin
            lock_vec <= press_vec;
        end
    end

    // pulse mode keeps only the first cycle of a press
    // typematic repeats leave press high, so no second pulse
    assign lock_mask = lock_vec & {`KBD_NUM_KEYS{pulse_mode}};
    assign keys      = press_vec & ~lock_mask;

endmodule

`default_nettype wire

//--- logic/keyboard_top.sv
// ps/2 keyboard front end top, chains receiver, decoder and key tracker
`default_nettype none

module keyboard_top
    import kbd_pkg::*;
(
    input  wire          clock,
    input  wire          reset,
    input  wire          ps2_clock,
    input  wire          ps2_data,
    input  wire          pulse_mode,
    output key_vector_t  keys,
    output logic         parity_error
);

    // receiver to decoder
    logic       byte_valid;
    scan_byte_t rx_byte;

    // decoder to tracker
    logic       key_valid;
    key_index_t key_index;
    logic       key_make;

    ps2_rx i_ps2_rx (
        .clock        (clock),
        .reset        (reset),
        .ps2_clock    (ps2_clock),
        .ps2_data     (ps2_data),
        .byte_valid   (byte_valid),
        .rx_byte      (rx_byte),
        .parity_error (parity_error)
    );

    scan_decoder i_scan_decoder (
        .clock      (clock),
        .reset      (reset),
        .byte_valid (byte_valid),
        .rx_byte    (rx_byte),
        .key_valid  (key_valid),
        .key_index  (key_index),
        .key_make   (key_make)
    );

    key_tracker i_key_tracker (
        .clock      (clock),
        .reset      (reset),
        .pulse_mode (pulse_mode),
        .key_valid  (key_valid),
        .key_index  (key_index),
        .key_make   (key_make),
        .keys       (keys)
    );

endmodule

`default_nettype wire

//--- logic/ps2_rx.sv
// ps/2 receive stage, turns the device clock and data lines into byte strobes for the decoder
`default_nettype none

`include "kbd_cfg.svh"

module ps2_rx
    import kbd_pkg::*;
(
    input  wire         clock,
    input  wire         reset,
    input  wire         ps2_clock,
    input  wire         ps2_data,
    output logic        byte_valid,
    output scan_byte_t  rx_byte,
    output logic        parity_error
);

    localparam int STALL_W = $clog2(`KBD_RX_TIMEOUT);
    // start, 8 data, parity, stop -> index of the stop bit
    localparam logic [3:0] LAST_BIT = 4'd10;

    // synchroniser stages, ps/2 clock in bit 1 and data in bit 0
    logic [1:0] line_meta;
    logic [1:0] line_sync;
    logic       clock_prev;
    logic       clock_fall;
    logic       data_bit;

    // frame assembly
    logic [9:0]         frame_shift;
    logic [3:0]         bit_count;
    logic [STALL_W-1:0] stall_count;
    logic               stall_expired;

    // frame checks, evaluated while the stop bit is on the line
    logic frame_end;
    logic start_ok;
    logic parity_ok;
    logic stop_ok;

    // idle-high reset value avoids a false edge at reset release
    always_ff @(posedge clock) begin
        if (!reset) begin
            line_meta  <= 2'b11;
            line_sync  <= 2'b11;
            clock_prev <= 1'b1;
        end else begin
            line_meta  <= {ps2_clock, ps2_data};
            line_sync  <= line_meta;
            clock_prev <= line_sync[1];
        end
    end

    // device changes data on the rising edge and the host samples on the falling edge
    assign clock_fall = clock_prev & ~line_sync[1];
    assign data_bit   = line_sync[0];

    // shift register fills from the top, lsb first on the wire
    // after ten bits: [0] start, [8:1] data, [9] parity
    assign frame_end = clock_fall && (bit_count == LAST_BIT);
    assign start_ok  = ~frame_shift[0];
    assign stop_ok   = data_bit;
    // odd parity over data plus parity bit
    assign parity_ok = ^frame_shift[9:1];

    assign stall_expired = (stall_count == STALL_W'(`KBD_RX_TIMEOUT - 1));

    // bit position within the frame and the mid-frame stall timer
    always_ff @(posedge clock) begin
        if (!reset) begin
            bit_count   <= '0;
            stall_count <= '0;
        end else if (clock_fall) begin
            stall_count <= '0;
            if (bit_count == LAST_BIT) begin
                bit_count <= '0;
            end else begin
                bit_count <= bit_count + 4'd1;
            end
        end else if ((bit_count != '0) && line_sync[1]) begin
            // clock stuck high mid-frame drops the partial frame
            if (stall_expired) begin
                bit_count   <= '0;
                stall_count <= '0;
            end else begin
                stall_count <= stall_count + 1'b1;
            end
        end
    end

    // one bit in per falling ps/2 clock edge
    always_ff @(posedge clock) begin
        if (clock_fall) begin
            frame_shift <= {data_bit, frame_shift[9:1]};
        end
    end

    // one-cycle strobes with the byte only for a clean frame
    always_ff @(posedge clock) begin
        if (!reset) begin
            byte_valid   <= 1'b0;
            parity_error <= 1'b0;
        end else begin
            byte_valid   <= frame_end && start_ok && stop_ok && parity_ok;
            // parity flagged only when framing itself looks sane
            parity_error <= frame_end && start_ok && stop_ok && !parity_ok;
        end
    end

    // byte payload, meaningful only alongside byte_valid
    always_ff @(posedge clock) begin
        if (frame_end) begin
            rx_byte <= frame_shift[8:1];
        end
    end

endmodule

`default_nettype wire

//--- logic/scan_decoder.sv
// scan code set 2 decoder, follows e0/f0 prefixes and turns tracked codes into key events
`default_nettype none

`include "kbd_cfg.svh"

module scan_decoder
    import kbd_pkg::*;
(
    input  wire         clock,
    input  wire         reset,
    input  wire         byte_valid,
    input  scan_byte_t  rx_byte,
    output logic        key_valid,
    output key_index_t  key_index,
    output logic        key_make
);

    decode_state_e state;
    decode_state_e next_state;

    // lookup result for the incoming byte
    logic       code_hit;
    key_index_t code_index;
    // only plain states act on key codes
    logic       plain_state;

    assign plain_state = (state == st_make) || (state == st_break);

    // code to key position
    // prefixes and untracked codes fall through to a miss
    always_comb begin
        code_hit   = 1'b1;
        code_index = '0;
        case (rx_byte)
            `KBD_CODE_0:        code_index = key_index_t'(`KBD_KEY_0);
            `KBD_CODE_1:        code_index = key_index_t'(`KBD_KEY_1);
            `KBD_CODE_2:        code_index = key_index_t'(`KBD_KEY_2);
            `KBD_CODE_3:        code_index = key_index_t'(`KBD_KEY_3);
            `KBD_CODE_4:        code_index = key_index_t'(`KBD_KEY_4);
            `KBD_CODE_5:        code_index = key_index_t'(`KBD_KEY_5);
            `KBD_CODE_6:        code_index = key_index_t'(`KBD_KEY_6);
            `KBD_CODE_7:        code_index = key_index_t'(`KBD_KEY_7);
            `KBD_CODE_8:        code_index = key_index_t'(`KBD_KEY_8);
            `KBD_CODE_9:        code_index = key_index_t'(`KBD_KEY_9);
            `KBD_CODE_MINUS:    code_index = key_index_t'(`KBD_KEY_MINUS);
            `KBD_CODE_LBRACKET: code_index = key_index_t'(`KBD_KEY_LBRACKET);
            `KBD_CODE_RBRACKET: code_index = key_index_t'(`KBD_KEY_RBRACKET);
            `KBD_CODE_SPACE:    code_index = key_index_t'(`KBD_KEY_SPACE);
            `KBD_CODE_ENTER:    code_index = key_index_t'(`KBD_KEY_ENTER);
            default:            code_hit   = 1'b0;
        endcase
    end

    // prefix tracking
    // any non-prefix byte closes the sequence
    always_comb begin
        next_state = st_make;
        if (rx_byte == `KBD_PREFIX_EXT) begin
            next_state = st_ext_make;
        end else if (rx_byte == `KBD_PREFIX_BREAK) begin
            // release of an extended key stays extended
            if ((state == st_ext_make) || (state == st_ext_break)) begin
                next_state = st_ext_break;
            end else begin
                next_state = st_break;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= st_make;
        end else if (byte_valid) begin
            state <= next_state;
        end
    end

    // event strobe one cycle after the byte strobe
    always_ff @(posedge clock) begin
        if (!reset) begin
            key_valid <= 1'b0;
        end else begin
            key_valid <= byte_valid && code_hit && plain_state;
        end
    end

    // event payload, read only with key_valid
    always_ff @(posedge clock) begin
        if (byte_valid) begin
            key_index <= code_index;
            // press in st_make, release after f0
            key_make  <= (state == st_make);
        end
    end

endmodule

`default_nettype wire

//--- sim/keyboard_assertions.sv
// protocol checks bound into the keyboard top, strobe widths, reset state and pulse output
`default_nettype none

module keyboard_assertions
    import kbd_pkg::*;
(
    input  wire          clock,
    input  wire          reset,
    input  wire          pulse_mode,
    input  wire          byte_valid,
    input  wire          key_valid,
    input  wire          parity_error,
    input  key_vector_t  keys
);

    // receiver strobe lasts a single cycle
    assert property (@(posedge clock) disable iff (!reset) byte_valid |=> !byte_valid)
        else $error("byte_valid stayed high for two cycles");

    // decoder strobe likewise
    assert property (@(posedge clock) disable iff (!reset) key_valid |=> !key_valid)
        else $error("key_valid stayed high for two cycles");

    // everything quiet in the cycle after a reset edge
    assert property (@(posedge clock)
        !reset |=> ((keys == '0) && !byte_valid && !key_valid && !parity_error))
        else $error("outputs not cleared after reset");

    // pulse mode, no key bit high on two cycles in a row
    assert property (@(posedge clock) disable iff (!reset)
        (pulse_mode && $past(pulse_mode)) |-> ((keys & $past(keys)) == '0))
        else $error("key pulse longer than one cycle");

endmodule

bind keyboard_top keyboard_assertions i_assertions (
    .clock        (clock),
    .reset        (reset),
    .pulse_mode   (pulse_mode),
    .byte_valid   (byte_valid),
    .key_valid    (key_valid),
    .parity_error (parity_error),
    .keys         (keys)
);

`default_nettype wire

//--- sim/keyboard_golden.txt
// columns: cmd byte flip keys count, all hex
// cmd 0 sends byte (flip 1 inverts parity), 1 sets pulse_mode to byte, 2 resets, f ends
// keys is the expected hold-mode vector, count the pulses seen since the previous line
0 16 0 0002 0
0 F0 0 0002 0
0 16 0 0000 0
0 45 0 0001 0
0 29 0 2001 0
0 5A 0 6001 0
0 F0 0 6001 0
0 29 0 4001 0
0 E0 0 4001 0
0 5A 0 4001 0
0 E0 0 4001 0
0 F0 0 4001 0
0 5A 0 4001 0
0 1C 0 4001 0
0 4E 0 4401 0
0 54 1 4401 0
0 54 0 4C01 0
0 F0 0 4C01 0
2 00 0 0000 0
0 3E 0 0100 0
1 01 0 0100 0
0 5B 0 1100 1
0 5B 0 1100 0
0 F0 0 1100 0
0 5B 0 0100 0
0 5B 0 1100 1
0 46 0 1300 1
0 E0 0 1300 0
0 46 0 1300 0
1 00 0 1300 0
0 26 0 1308 0
f 00 0 0000 0

//--- sim/keyboard_tb.sv
// testbench for the keyboard front end, replays golden vectors as ps/2 frames and checks keys
`default_nettype none

`include "kbd_cfg.svh"

module keyboard_tb
    import kbd_pkg::*;
();

    localparam int STROBE_LIMIT = 2000;
    localparam int MAX_VECTORS  = 51;

    logic        clock;
    logic        reset;
    logic        ps2_clock;
    logic        ps2_data;
    logic        pulse_mode;
    key_vector_t keys;
    logic        parity_error;

    // five hex words per golden vector
    logic [15:0] golden_mem [0:255];
    logic [31:0] rnd_state;
    int          vector_no;

    // running totals sampled on falling edges
    int byte_total   = 0;
    int parity_total = 0;
    int pulse_total  = 0;

    // reference model of decoder and tracker
    key_vector_t   model_keys;
    decode_state_e model_state;
    int            model_pulses;

    keyboard_top i_dut (
        .clock        (clock),
        .reset        (reset),
        .ps2_clock    (ps2_clock),
        .ps2_data     (ps2_data),
        .pulse_mode   (pulse_mode),
        .keys         (keys),
        .parity_error (parity_error)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #4 clock = ~clock;
        end
    end

    // receiver strobe probed inside the top level
    always @(negedge clock) begin
        if (i_dut.byte_valid) begin
            byte_total <= byte_total + 1;
        end
        if (parity_error) begin
            parity_total <= parity_total + 1;
        end
        if (pulse_mode) begin
            pulse_total <= pulse_total + $countones(keys);
        end
    end

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // key position of a tracked make code or -1
    function automatic int key_of_code(input scan_byte_t code);
        case (code)
            `KBD_CODE_0:        return `KBD_KEY_0;
            `KBD_CODE_1:        return `KBD_KEY_1;
            `KBD_CODE_2:        return `KBD_KEY_2;
            `KBD_CODE_3:        return `KBD_KEY_3;
            `KBD_CODE_4:        return `KBD_KEY_4;
            `KBD_CODE_5:        return `KBD_KEY_5;
            `KBD_CODE_6:        return `KBD_KEY_6;
            `KBD_CODE_7:        return `KBD_KEY_7;
            `KBD_CODE_8:        return `KBD_KEY_8;
            `KBD_CODE_9:        return `KBD_KEY_9;
            `KBD_CODE_MINUS:    return `KBD_KEY_MINUS;
            `KBD_CODE_LBRACKET: return `KBD_KEY_LBRACKET;
            `KBD_CODE_RBRACKET: return `KBD_KEY_RBRACKET;
            `KBD_CODE_SPACE:    return `KBD_KEY_SPACE;
            `KBD_CODE_ENTER:    return `KBD_KEY_ENTER;
            default:            return -1;
        endcase
    endfunction

    task automatic wait_cycles(input int n);
        int i;
        for (i = 0; i < n; i++) begin
            @(posedge clock);
        end
    endtask

    task automatic check_keys(input key_vector_t actual, input key_vector_t expected,
                              input string what);
        if (actual !== expected) begin
            $display("ERROR: time %0t: %s at vector %0d, got %h expected %h",
                     $time, what, vector_no, actual, expected);
            $display("TEST FAIL");
            $fatal(1, "key vector mismatch");
        end
    endtask

    task automatic check_count(input int actual, input int expected, input string what);
        if (actual !== expected) begin
            $display("ERROR: time %0t: %s at vector %0d, got %0d expected %0d",
                     $time, what, vector_no, actual, expected);
            $display("TEST FAIL");
            $fatal(1, "count mismatch");
        end
    endtask

    // poll a running total until it reaches target
    task automatic wait_for_strobe(input bit parity_strobe, input int target, input string what);
        int cycles;
        int seen;
        cycles = 0;
        seen   = parity_strobe ? parity_total : byte_total;
        while ((seen < target) && (cycles < STROBE_LIMIT)) begin
            @(posedge clock);
            cycles++;
            seen = parity_strobe ? parity_total : byte_total;
        end
        if (seen < target) begin
            $display("timeout: no %s within %0d cycles at vector %0d",
                     what, STROBE_LIMIT, vector_no);
            $display("TEST FAIL");
            $fatal(1, "strobe wait timed out");
        end
    endtask

    // frame is start, data lsb first, odd parity and stop
    // data changes while the ps/2 clock is high
    task automatic send_frame(input scan_byte_t value, input logic flip_parity);
        logic [10:0] frame;
        int          half;
        int          n;
        frame = {1'b1, (~^value) ^ flip_parity, value, 1'b0};
        for (n = 0; n < 11; n++) begin
            rnd_state = next_random(rnd_state);
            half = 20 + int'(rnd_state % 32'd21);
            @(posedge clock);
            ps2_data <= frame[0];
            frame = frame >> 1;
            wait_cycles(half);
            ps2_clock <= 1'b0;
            wait_cycles(half);
            ps2_clock <= 1'b1;
        end
        @(posedge clock);
        ps2_data <= 1'b1;
    endtask

    // e0 starts an ignored sequence and f0 turns the next code into a release
    task automatic update_model(input scan_byte_t value);
        int         k;
        key_index_t idx;
        k = key_of_code(value);
        idx = key_index_t'(k);
        if (value == `KBD_PREFIX_EXT) begin
            model_state = st_ext_make;
        end else if (value == `KBD_PREFIX_BREAK) begin
            if ((model_state == st_ext_make) || (model_state == st_ext_break)) begin
                model_state = st_ext_break;
            end else begin
                model_state = st_break;
            end
        end else begin
            if ((k >= 0) && (model_state == st_make)) begin
                // only a fresh press pulses
                if (!model_keys[idx] && pulse_mode) begin
                    model_pulses++;
                end
                model_keys[idx] = 1'b1;
            end else if ((k >= 0) && (model_state == st_break)) begin
                model_keys[idx] = 1'b0;
            end
            model_state = st_make;
        end
    endtask

    initial begin
        logic [7:0]  addr;
        int          cmd;
        scan_byte_t  value;
        logic        flip;
        key_vector_t golden_keys;
        int          golden_count;
        int          pulse_mark;
        int          byte_mark;
        int          parity_mark;
        int          bytes_expected;
        int          parity_expected;
        bit          done;

        reset       = 1'b0;
        ps2_clock   = 1'b1;
        ps2_data    = 1'b1;
        pulse_mode  = 1'b0;
        rnd_state   = 32'd13812;
        model_keys  = '0;
        model_state = st_make;
        done        = 1'b0;
        vector_no   = 0;
        $readmemh("sim/keyboard_golden.txt", golden_mem);
        wait_cycles(5);
        reset <= 1'b1;
        wait_cycles(2);
        @(negedge clock);

        while (!done) begin
            addr         = 8'(vector_no * 5);
            cmd          = int'(golden_mem[addr]);
            value        = golden_mem[addr + 8'd1][7:0];
            flip         = golden_mem[addr + 8'd2][0];
            golden_keys  = golden_mem[addr + 8'd3][`KBD_NUM_KEYS-1:0];
            golden_count = int'(golden_mem[addr + 8'd4]);
            pulse_mark   = pulse_total;
            byte_mark    = byte_total;
            parity_mark  = parity_total;
            model_pulses = 0;
            bytes_expected  = 0;
            parity_expected = 0;
            case (cmd)
                0: begin
                    if (flip) begin
                        parity_expected = 1;
                        send_frame(value, 1'b1);
                        wait_for_strobe(1'b1, parity_mark + 1, "parity error strobe");
                    end else begin
                        bytes_expected = 1;
                        send_frame(value, 1'b0);
                        wait_for_strobe(1'b0, byte_mark + 1, "byte strobe");
                        update_model(value);
                    end
                    // decoder and tracker take one cycle each
                    wait_cycles(3);
                end
                1: begin
                    @(posedge clock);
                    pulse_mode <= value[0];
                    wait_cycles(2);
                end
                2: begin
                    @(posedge clock);
                    reset <= 1'b0;
                    wait_cycles(5);
                    reset <= 1'b1;
                    model_keys  = '0;
                    model_state = st_make;
                    wait_cycles(2);
                end
                default: begin
                    done = 1'b1;
                end
            endcase
            if (!done) begin
                @(negedge clock);
                check_keys(model_keys, golden_keys, "model keys against golden");
                // pulse mode output has settled back to zero by now
                check_keys(keys, pulse_mode ? key_vector_t'(0) : model_keys, "keys output");
                check_count(model_pulses, golden_count, "model pulses against golden");
                check_count(pulse_total - pulse_mark, golden_count, "key pulses");
                check_count(byte_total - byte_mark, bytes_expected, "byte strobes");
                check_count(parity_total - parity_mark, parity_expected,
                            "parity error strobes");
                vector_no++;
                if (vector_no >= MAX_VECTORS) begin
                    done = 1'b1;
                end
            end
        end

        if (vector_no == 0) begin
            $display("no golden vectors were read from the data file");
            $display("TEST FAIL");
            $fatal(1, "empty golden file");
        end else begin
            $display("%0d golden vectors checked", vector_no);
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire
